// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = matInvTb
FLIST = flist.f
BUILD = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the $(TOP) testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== augmentedMatrix.sv ====
`default_nettype none

module augmentedMatrix
	import matInvPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	elemWriteIf.store  wr,
	rowOpIf.store      op,
	output augMatrix_t matrix
);

	augMatrix_t mat;
	elem_t      tgtPivCol;
	elem_t      pivDiag;
	logic       skip;
	logic       skipStep;

	// cross-multiplication factors for the current pair
	assign tgtPivCol = mat[op.target][op.pivot];
	assign pivDiag   = mat[op.pivot][op.pivot];
	// nothing to clear in this column
	assign skip      = (tgtPivCol == '0);

	assign matrix = mat;

	always_ff @(posedge clk)
	begin
		// skip is decided once per step, at the scale cycle
		if (op.op == OP_SCALE)
			skipStep <= skip;

		if (wr.write)
		begin
			mat[wr.row][wr.col] <= wr.data;
			// right half builds up the identity as the rows arrive
			mat[wr.row][wr.col + MAT_N] <= (wr.row == wr.col) ? elem_t'(1) : elem_t'(0);
		end
		else if (op.op == OP_SCALE && !skip)
		begin
			for (int c = 0; c < AUG_COLS; c++)
			begin
				mat[op.pivot][c]  <= mat[op.pivot][c] * tgtPivCol;
				mat[op.target][c] <= mat[op.target][c] * pivDiag;
			end
		end
		else if (op.op == OP_SUBTRACT && !skipStep)
		begin
			for (int c = 0; c < AUG_COLS; c++)
				mat[op.target][c] <= mat[op.target][c] - mat[op.pivot][c];
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// loading and elimination are separate phases
	noOverlap: assert property (@(posedge clk) disable iff (reset)
		!(wr.write && op.op != OP_NONE));

	// step table never pairs a row with itself
	distinctRows: assert property (@(posedge clk) disable iff (reset)
		(op.op != OP_NONE) |-> (op.pivot != op.target));

endmodule

`default_nettype wire

// ==== flist.f ====
matInvPkg.sv
matInvIf.sv
inputLoader.sv
stepSequencer.sv
augmentedMatrix.sv
resultStreamer.sv
matInvTop.sv
matInvTb.sv

// ==== inputLoader.sv ====
`default_nettype none

module inputLoader
	import matInvPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       inValid,
	input  elem_t      inData,
	output logic       matrixCredit,
	input  logic       streamDone,
	output logic       loadDone,
	elemWriteIf.loader wr
);

	logic    creditDue;
	logic    armed;
	logic    accept;
	logic    lastElem;
	rowIdx_t rowCnt;
	rowIdx_t colCnt;

	// elements only count while a matrix credit is outstanding
	assign accept   = inValid && armed;
	assign lastElem = (rowCnt == MAT_N-1) && (colCnt == MAT_N-1);
	assign loadDone = accept && lastElem;

	assign wr.write = accept;
	assign wr.row   = rowCnt;
	assign wr.col   = colCnt;
	assign wr.data  = inData;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// first credit goes out right after reset
			creditDue    <= 1'b1;
			matrixCredit <= 1'b0;
			armed        <= 1'b0;
			rowCnt       <= '0;
			colCnt       <= '0;
		end
		else
		begin
			matrixCredit <= creditDue || streamDone;
			creditDue    <= 1'b0;
			if (creditDue || streamDone)
				armed <= 1'b1;
			else if (loadDone)
				armed <= 1'b0;

			// row-major walk over the left half
			if (accept)
			begin
				if (lastElem)
				begin
					rowCnt <= '0;
					colCnt <= '0;
				end
				else if (colCnt == MAT_N-1)
				begin
					colCnt <= '0;
					rowCnt <= rowCnt + 1'b1;
				end
				else
					colCnt <= colCnt + 1'b1;
			end
		end
	end

	// source must wait for matrixCredit before sending a matrix
	creditHeld: assert property (@(posedge clk) disable iff (reset) inValid |-> armed);

endmodule

`default_nettype wire

// ==== matInvIf.sv ====
`default_nettype none

// element writes from the loader into the matrix store
interface elemWriteIf import matInvPkg::*; ();
	logic    write;
	rowIdx_t row;
	rowIdx_t col;
	elem_t   data;

	modport loader (output write, row, col, data);
	modport store (input write, row, col, data);
endinterface

// row operations from the sequencer, applied on the next edge
interface rowOpIf import matInvPkg::*; ();
	rowOp_t  op;
	rowIdx_t pivot;
	rowIdx_t target;

	modport sequencer (output op, pivot, target);
	modport store (input op, pivot, target);
endinterface

`default_nettype wire

// ==== matInvPkg.sv ====
`default_nettype none

package matInvPkg;

	////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////

	localparam int DATA_WIDTH  = 64;
	localparam int MAT_N       = 5;
	// left half is the input matrix, right half starts as identity
	localparam int AUG_COLS    = 10;
	localparam int NUM_STEPS   = 20;
	// 25 right-half words plus the diagonal product
	localparam int OUT_WORDS   = 26;
	localparam int OUT_CREDITS = 4;

	////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////

	typedef logic signed [DATA_WIDTH-1:0] elem_t;
	typedef logic [2:0] rowIdx_t;
	typedef elem_t [AUG_COLS-1:0] augRow_t;
	typedef augRow_t [MAT_N-1:0] augMatrix_t;

	typedef enum logic [1:0] {OP_NONE, OP_SCALE, OP_SUBTRACT} rowOp_t;
	typedef enum logic [1:0] {SEQ_IDLE, SEQ_SCALE, SEQ_SUBTRACT, SEQ_DONE} seqState_t;
	typedef enum logic [1:0] {STR_IDLE, STR_PRODUCT, STR_SEND, STR_DET} streamState_t;

endpackage

`default_nettype wire

// ==== matInvTb.sv ====
`default_nettype none

module matInvTb
	import matInvPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	typedef elem_t [MAT_N*MAT_N-1:0] inMat_t;
	typedef elem_t [OUT_WORDS-1:0] result_t;

	localparam int CREDIT_TIMEOUT = 3000;
	localparam int DRAIN_TIMEOUT  = 3000;

	logic  clk;
	logic  reset;
	logic  inValid;
	elem_t inData;
	logic  matrixCredit;
	logic  outValid;
	elem_t outData;
	logic  outLast;
	logic  outCredit;

	elem_t       expQ[$];
	elem_t       expWord;
	int          wordIdx;
	int          wordsSeen;
	int          creditsReturned;
	int          creditPulses;
	int          matricesSent;
	int          sinkCycle;
	logic        backPressure;
	int unsigned lcgState;
	inMat_t      matA;
	inMat_t      matB;

	matInvTop DUT (
		.clk          (clk),
		.reset        (reset),
		.inValid      (inValid),
		.inData       (inData),
		.matrixCredit (matrixCredit),
		.outValid     (outValid),
		.outData      (outData),
		.outLast      (outLast),
		.outCredit    (outCredit)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	function automatic int unsigned lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 16;
	endfunction

	// entries from -8 to 7, about one in five forced to zero
	function automatic inMat_t randomMatrix();
		inMat_t m;
		for (int i = 0; i < MAT_N*MAT_N; i++)
		begin
			m[i] = elem_t'(int'(lcgNext() % 16) - 8);
			if (lcgNext() % 5 == 0)
				m[i] = '0;
		end
		return m;
	endfunction

	function automatic inMat_t identityMatrix();
		inMat_t m;
		for (int i = 0; i < MAT_N*MAT_N; i++)
			m[i] = (i / MAT_N == i % MAT_N) ? elem_t'(1) : elem_t'(0);
		return m;
	endfunction

	// tridiagonal test matrix
	function automatic inMat_t bandedMatrix();
		inMat_t m;
		int r;
		int c;
		for (int i = 0; i < MAT_N*MAT_N; i++)
		begin
			r = i / MAT_N;
			c = i % MAT_N;
			if (r == c)
				m[i] = elem_t'(r + 2);
			else if (r - c == 1 || c - r == 1)
				m[i] = elem_t'(-1);
			else
				m[i] = '0;
		end
		return m;
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// one cross-multiplication step on pivot p, target t
	function automatic augMatrix_t rowStep(input augMatrix_t m, input int p, input int t);
		augMatrix_t r;
		elem_t f;
		elem_t d;
		r = m;
		f = r[t][p];
		d = r[p][p];
		// a zero in column p skips the whole step
		if (f != '0)
		begin
			for (int c = 0; c < AUG_COLS; c++)
			begin
				r[p][c] = r[p][c] * f;
				r[t][c] = r[t][c] * d;
			end
			for (int c = 0; c < AUG_COLS; c++)
				r[t][c] = r[t][c] - r[p][c];
		end
		return r;
	endfunction

	function automatic result_t refSolve(input inMat_t a);
		augMatrix_t m;
		result_t res;
		elem_t prod;
		for (int r = 0; r < MAT_N; r++)
		begin
			for (int c = 0; c < MAT_N; c++)
			begin
				m[r][c] = a[r*MAT_N + c];
				m[r][c + MAT_N] = (r == c) ? elem_t'(1) : elem_t'(0);
			end
		end
		// forward pass, then backward pass
		for (int p = 0; p < MAT_N-1; p++)
			for (int t = p + 1; t < MAT_N; t++)
				m = rowStep(m, p, t);
		for (int p = MAT_N-1; p > 0; p--)
			for (int t = p - 1; t >= 0; t--)
				m = rowStep(m, p, t);
		prod = elem_t'(1);
		for (int r = 0; r < MAT_N; r++)
		begin
			prod = prod * m[r][r];
			for (int c = 0; c < MAT_N; c++)
				res[r*MAT_N + c] = m[r][c + MAT_N];
		end
		res[OUT_WORDS-1] = prod;
		return res;
	endfunction

	task automatic queueExpected(input result_t r);
		for (int i = 0; i < OUT_WORDS; i++)
			expQ.push_back(r[i]);
	endtask

	////////////////////////////////////////////////////////////
	// compare
	////////////////////////////////////////////////////////////

	task automatic checkEntry(input elem_t got, input elem_t exp, input int idx, input logic last);
		if (got !== exp)
			stopRun($sformatf("ERR %0t: word %0d is %0d, expected %0d", $time, idx, got, exp));
		if (last !== 1'b0)
			stopRun($sformatf("ERR %0t: outLast high on word %0d", $time, idx));
	endtask

	task automatic checkDet(input elem_t got, input elem_t exp, input logic last);
		if (got !== exp)
			stopRun($sformatf("ERR %0t: determinant is %0d, expected %0d", $time, got, exp));
		if (last !== 1'b1)
			stopRun($sformatf("ERR %0t: outLast low on the determinant word", $time));
	endtask

	// monitor, sampled mid-cycle
	initial
	begin
		wordsSeen       = 0;
		creditsReturned = 0;
		creditPulses    = 0;
		wordIdx         = 0;
		forever
		begin
			@(negedge clk);
			if (!reset)
			begin
				if (matrixCredit)
					creditPulses++;
				if (outValid)
				begin
					wordsSeen++;
					if (wordsSeen > OUT_CREDITS + creditsReturned)
						stopRun($sformatf("ERR %0t: word %0d sent without a credit",
							$time, wordsSeen));
					if (expQ.size() == 0)
						stopRun("outValid went high while no matrix was outstanding");
					expWord = expQ.pop_front();
					if (wordIdx == OUT_WORDS-1)
						checkDet(outData, expWord, outLast);
					else
						checkEntry(outData, expWord, wordIdx, outLast);
					wordIdx = (wordIdx + 1) % OUT_WORDS;
				end
				if (outCredit)
					creditsReturned++;
			end
		end
	end

	// sink hands back one credit per taken word, or holds them back
	initial
	begin
		outCredit = 1'b0;
		sinkCycle = 0;
		forever
		begin
			@(posedge clk);
			sinkCycle++;
			if (!reset && wordsSeen > creditsReturned
				&& !(backPressure && (sinkCycle % 40) < 34))
				outCredit <= 1'b1;
			else
				outCredit <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic sendMatrix(input inMat_t a, input logic gaps);
		int cycles;
		int gap;
		cycles = 0;
		while (creditPulses <= matricesSent)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > CREDIT_TIMEOUT)
				stopRun("timed out waiting for matrixCredit");
		end
		matricesSent++;
		for (int i = 0; i < MAT_N*MAT_N; i++)
		begin
			gap = gaps ? int'(lcgNext() % 3) : 0;
			repeat (gap)
			begin
				@(posedge clk);
				inValid <= 1'b0;
			end
			@(posedge clk);
			inValid <= 1'b1;
			inData  <= a[i];
		end
		@(posedge clk);
		inValid <= 1'b0;
	endtask

	task automatic waitDrained();
		int cycles;
		cycles = 0;
		while (expQ.size() != 0)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > DRAIN_TIMEOUT)
				stopRun("timed out waiting for the result stream to finish");
		end
	endtask

	initial
	begin
		lcgState     = 15447;
		reset        = 1'b1;
		inValid      = 1'b0;
		inData       = '0;
		backPressure = 1'b0;
		matricesSent = 0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// single credit after reset, and nothing on the output
		for (int cycles = 0; creditPulses == 0; cycles++)
		begin
			@(negedge clk);
			if (cycles > CREDIT_TIMEOUT)
				stopRun("no matrixCredit after reset");
		end
		repeat (10) @(negedge clk);
		if (creditPulses != 1)
			stopRun("matrixCredit did not pulse exactly once after reset");

		// identity, every step skipped
		for (int i = 0; i < OUT_WORDS-1; i++)
			expQ.push_back((i / MAT_N == i % MAT_N) ? elem_t'(1) : elem_t'(0));
		expQ.push_back(elem_t'(1));
		sendMatrix(identityMatrix(), 1'b0);
		waitDrained();

		matA = bandedMatrix();
		queueExpected(refSolve(matA));
		sendMatrix(matA, 1'b1);
		waitDrained();

		for (int n = 0; n < 6; n++)
		begin
			matA = randomMatrix();
			queueExpected(refSolve(matA));
			sendMatrix(matA, 1'b1);
			waitDrained();
		end

		// long credit stalls from the sink
		backPressure = 1'b1;
		for (int n = 0; n < 2; n++)
		begin
			matA = randomMatrix();
			queueExpected(refSolve(matA));
			sendMatrix(matA, 1'b1);
			waitDrained();
		end
		backPressure = 1'b0;

		// second matrix goes in as soon as the next credit arrives
		matA = randomMatrix();
		matB = randomMatrix();
		queueExpected(refSolve(matA));
		queueExpected(refSolve(matB));
		sendMatrix(matA, 1'b0);
		sendMatrix(matB, 1'b0);
		waitDrained();

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== matInvTop.sv ====
`default_nettype none

module matInvTop
	import matInvPkg::*;
(
	input  logic  clk,
	input  logic  reset,
	// element stream in, one matrix per credit
	input  logic  inValid,
	input  elem_t inData,
	output logic  matrixCredit,
	// result stream out, per-word credits
	output logic  outValid,
	output elem_t outData,
	output logic  outLast,
	input  logic  outCredit
);

	elemWriteIf wr ();
	rowOpIf     op ();

	logic       loadDone;
	logic       solveDone;
	logic       streamDone;
	augMatrix_t matrix;

	inputLoader loader (
		.clk          (clk),
		.reset        (reset),
		.inValid      (inValid),
		.inData       (inData),
		.matrixCredit (matrixCredit),
		.streamDone   (streamDone),
		.loadDone     (loadDone),
		.wr           (wr.loader)
	);

	stepSequencer sequencer (
		.clk       (clk),
		.reset     (reset),
		.loadDone  (loadDone),
		.solveDone (solveDone),
		.op        (op.sequencer)
	);

	augmentedMatrix store (
		.clk    (clk),
		.reset  (reset),
		.wr     (wr.store),
		.op     (op.store),
		.matrix (matrix)
	);

	resultStreamer streamer (
		.clk        (clk),
		.reset      (reset),
		.solveDone  (solveDone),
		.matrix     (matrix),
		.outValid   (outValid),
		.outLast    (outLast),
		.outData    (outData),
		.outCredit  (outCredit),
		.streamDone (streamDone)
	);

endmodule

`default_nettype wire

// ==== resultStreamer.sv ====
`default_nettype none

module resultStreamer
	import matInvPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       solveDone,
	input  augMatrix_t matrix,
	output logic       outValid,
	output logic       outLast,
	output elem_t      outData,
	input  logic       outCredit,
	output logic       streamDone
);

	streamState_t state;
	rowIdx_t      rowCnt;
	rowIdx_t      colCnt;
	logic [4:0]   wordCnt;
	logic [2:0]   credits;
	elem_t        det;

	assign outValid   = (state == STR_SEND || state == STR_DET) && (credits != '0);
	assign outLast    = outValid && (state == STR_DET);
	assign outData    = (state == STR_DET) ? det : matrix[rowCnt][colCnt + MAT_N];
	// last word is on the bus this cycle
	assign streamDone = outLast;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state   <= STR_IDLE;
			rowCnt  <= '0;
			colCnt  <= '0;
			wordCnt <= '0;
		end
		else
		begin
			case (state)
				STR_IDLE:
					if (solveDone)
					begin
						state  <= STR_PRODUCT;
						rowCnt <= '0;
					end
				STR_PRODUCT:
					if (rowCnt == MAT_N-1)
					begin
						state   <= STR_SEND;
						rowCnt  <= '0;
						colCnt  <= '0;
						wordCnt <= '0;
					end
					else
						rowCnt <= rowCnt + 1'b1;
				STR_SEND:
					if (outValid)
					begin
						wordCnt <= wordCnt + 1'b1;
						if (colCnt == MAT_N-1)
						begin
							colCnt <= '0;
							rowCnt <= rowCnt + 1'b1;
						end
						else
							colCnt <= colCnt + 1'b1;
						if (wordCnt == OUT_WORDS-2)
							state <= STR_DET;
					end
				default:
					if (outValid)
						state <= STR_IDLE;
			endcase
		end
	end

	// diagonal product, one entry per cycle
	always_ff @(posedge clk)
	begin
		if (state == STR_IDLE)
			det <= elem_t'(1);
		else if (state == STR_PRODUCT)
			det <= det * matrix[rowCnt][rowCnt];
	end

	////////////////////////////////////////////////////////////
	// output credits
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			credits <= 3'(OUT_CREDITS);
		else
		begin
			case ({outCredit, outValid})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// sink returns no more credits than words it took
	creditBound: assert property (@(posedge clk) disable iff (reset)
		credits <= OUT_CREDITS);

endmodule

`default_nettype wire

// ==== stepSequencer.sv ====
`default_nettype none

module stepSequencer
	import matInvPkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         loadDone,
	output logic         solveDone,
	rowOpIf.sequencer    op
);

	seqState_t  state;
	logic [4:0] step;
	logic       lastStep;
	rowOp_t     opCode;

	////////////////////////////////////////////////////////////
	// elimination order, {pivot, target}
	////////////////////////////////////////////////////////////

	function automatic logic [5:0] stepPair(input logic [4:0] s);
		case (s)
			// forward pass clears below the diagonal
			5'd0:  stepPair = {3'd0, 3'd1};
			5'd1:  stepPair = {3'd0, 3'd2};
			5'd2:  stepPair = {3'd0, 3'd3};
			5'd3:  stepPair = {3'd0, 3'd4};
			5'd4:  stepPair = {3'd1, 3'd2};
			5'd5:  stepPair = {3'd1, 3'd3};
			5'd6:  stepPair = {3'd1, 3'd4};
			5'd7:  stepPair = {3'd2, 3'd3};
			5'd8:  stepPair = {3'd2, 3'd4};
			5'd9:  stepPair = {3'd3, 3'd4};
			// backward pass clears above it
			5'd10: stepPair = {3'd4, 3'd3};
			5'd11: stepPair = {3'd4, 3'd2};
			5'd12: stepPair = {3'd4, 3'd1};
			5'd13: stepPair = {3'd4, 3'd0};
			5'd14: stepPair = {3'd3, 3'd2};
			5'd15: stepPair = {3'd3, 3'd1};
			5'd16: stepPair = {3'd3, 3'd0};
			5'd17: stepPair = {3'd2, 3'd1};
			5'd18: stepPair = {3'd2, 3'd0};
			default: stepPair = {3'd1, 3'd0};
		endcase
	endfunction

	assign lastStep  = (step == NUM_STEPS-1);
	assign solveDone = (state == SEQ_SUBTRACT) && lastStep;

	always_comb
	begin
		case (state)
			SEQ_SCALE:    opCode = OP_SCALE;
			SEQ_SUBTRACT: opCode = OP_SUBTRACT;
			default:      opCode = OP_NONE;
		endcase
	end

	assign op.op = opCode;
	assign {op.pivot, op.target} = stepPair(step);

	// two cycles per step, skipped or not
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= SEQ_IDLE;
			step  <= '0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
					if (loadDone)
					begin
						state <= SEQ_SCALE;
						step  <= '0;
					end
				SEQ_SCALE:
					state <= SEQ_SUBTRACT;
				SEQ_SUBTRACT:
					if (lastStep)
						state <= SEQ_DONE;
					else
					begin
						state <= SEQ_SCALE;
						step  <= step + 1'b1;
					end
				default:
					state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire
